// ==== vlog.f ====
verilog/panel_pkg.sv
verilog/step_counter_if.sv
verilog/step_counter.sv
verilog/tick_gen.sv
verilog/switch_to_counter.sv
verilog/button_panel.sv
bench/button_panel_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Compile and run the button panel testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f vlog.f --top-module button_panel_tb \
	-o button_panel_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/button_panel_sim > sim.log 2>&1 || echo "Simulation exited with an error"
cat sim.log

grep -q "^TEST RESULT: PASS$" sim.log && echo "Simulation passed" && exit 0 \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// ==== bench/button_panel_tb.sv ====
// ******************************
// Button panel testbench
// ******************************

`timescale 1ns/100ps

module button_panel_tb;

	import panel_pkg::*;

	localparam int unsigned NUM_SWITCH = 4;
	localparam int unsigned CLK_PER_TICK = 5;
	localparam int unsigned LOCK_TICKS = 6;

	// ******************************
	// Phase lengths in cycles
	// ******************************

	localparam int unsigned RESET_CYC = 8;
	localparam int unsigned SETTLE_CYC = 60;
	localparam int unsigned WRAP_PRESSES = 260;
	localparam int unsigned WRAP_PERIOD = 40;
	localparam int unsigned RAND_CYC = 6000;
	localparam int unsigned TOTAL_CYC = RESET_CYC + 10 + (10 + SETTLE_CYC)
		+ (17 + SETTLE_CYC + 10 + SETTLE_CYC) + (100 + SETTLE_CYC)
		+ (WRAP_PRESSES * WRAP_PERIOD + SETTLE_CYC) + (RAND_CYC + SETTLE_CYC);
	// Run limit with a 10% margin
	localparam int unsigned CYCLE_LIMIT = TOTAL_CYC + TOTAL_CYC / 10;

	logic clk;
	logic rstnn;
	logic [NUM_SWITCH-1:0] switch_input;
	switch_count_t [NUM_SWITCH-1:0] value;

	// Model state with one entry per channel
	int unsigned mdl_div;
	logic [NUM_SWITCH-1:0] mdl_sync1;
	logic [NUM_SWITCH-1:0] mdl_sync2;
	logic [NUM_SWITCH-1:0] mdl_locked;
	int unsigned mdl_timer [NUM_SWITCH];
	switch_count_t mdl_count [NUM_SWITCH];

	// Cycles left before each switch flips in the random phase
	int unsigned hold_left [NUM_SWITCH];
	int unsigned cycle_cnt;

	button_panel
	#(
		.NUM_SWITCH(NUM_SWITCH),
		.ACTIVE_HIGH(1'b0),
		.CLK_PER_TICK(CLK_PER_TICK),
		.LOCK_TICKS(LOCK_TICKS)
	)
	dut0
	(
		.clk(clk),
		.rstnn(rstnn),
		.switch_input(switch_input),
		.value(value)
	);

	always #2 clk = ~clk;

	// ******************************
	// Reference model
	// ******************************

	always @(posedge clk or negedge rstnn)
	begin : model
		bit tick_now;
		if (!rstnn)
		begin
			mdl_div <= 0;
			mdl_sync1 <= '0;
			mdl_sync2 <= '0;
			mdl_locked <= '0;
			for (int ch = 0; ch < NUM_SWITCH; ch++)
			begin
				mdl_timer[ch] <= 0;
				mdl_count[ch] <= '0;
			end
		end
		else
		begin
			// Tick in the last cycle of every divider period
			tick_now = (mdl_div == CLK_PER_TICK - 1);
			mdl_div <= tick_now ? 0 : mdl_div + 1;
			// Switch pulls low when pressed
			mdl_sync1 <= ~switch_input;
			mdl_sync2 <= mdl_sync1;
			for (int ch = 0; ch < NUM_SWITCH; ch++)
			begin
				if (!mdl_locked[ch])
				begin
					if (mdl_sync2[ch])
					begin
						mdl_count[ch] <= mdl_count[ch] + 1'b1;
						mdl_locked[ch] <= 1'b1;
					end
				end
				else if (tick_now)
				begin
					// Lockout ends after LOCK_TICKS ticks
					if (mdl_timer[ch] == LOCK_TICKS - 1)
					begin
						mdl_timer[ch] <= 0;
						mdl_locked[ch] <= 1'b0;
					end
					else
					begin
						mdl_timer[ch] <= mdl_timer[ch] + 1;
					end
				end
			end
		end
	end

	// ******************************
	// Checks and limits
	// ******************************

	task automatic check_count(input int ch, input switch_count_t expected,
		input switch_count_t actual);
		if (actual !== expected)
		begin
			$display("ERR %0t ns: channel %0d count expected %0d got %0d",
				$time, ch, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "count mismatch");
		end
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk)
	begin
		for (int ch = 0; ch < NUM_SWITCH; ch++)
		begin
			check_count(ch, mdl_count[ch], value[ch]);
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic wait_cycles(input int unsigned n);
		repeat (n) @(posedge clk);
	endtask

	task automatic set_switch(input int ch, input logic level);
		@(posedge clk);
		switch_input[ch] <= level;
	endtask

	// ******************************
	// Stimulus
	// ******************************

	initial
	begin
		clk = 1'b0;
		rstnn = 1'b0;
		switch_input = '1;
		cycle_cnt = 0;
		void'($urandom(32'hddfc));
		wait_cycles(RESET_CYC);
		rstnn <= 1'b1;
		wait_cycles(10);

		// Single clean press on channel 0
		set_switch(0, 1'b0);
		wait_cycles(9);
		set_switch(0, 1'b1);
		wait_cycles(SETTLE_CYC);
		@(negedge clk);
		check_count(0, 8'd1, value[0]);

		// Bounces on channel 1 inside the lockout and a later press
		set_switch(1, 1'b0);
		repeat (16)
		begin
			@(posedge clk);
			switch_input[1] <= 1'($urandom_range(1, 0));
		end
		set_switch(1, 1'b1);
		wait_cycles(SETTLE_CYC);
		set_switch(1, 1'b0);
		wait_cycles(9);
		set_switch(1, 1'b1);
		wait_cycles(SETTLE_CYC);
		@(negedge clk);
		check_count(1, 8'd2, value[1]);

		// Channel 3 held down for 100 cycles auto-repeats
		// First count plus three completed lockouts of about 30 cycles
		set_switch(3, 1'b0);
		wait_cycles(99);
		set_switch(3, 1'b1);
		wait_cycles(SETTLE_CYC);
		@(negedge clk);
		check_count(3, 8'd4, value[3]);

		// Enough presses on channel 2 to wrap past 255
		repeat (WRAP_PRESSES)
		begin
			set_switch(2, 1'b0);
			wait_cycles(7);
			set_switch(2, 1'b1);
			wait_cycles(WRAP_PERIOD - 9);
		end
		wait_cycles(SETTLE_CYC);
		@(negedge clk);
		check_count(2, 8'd4, value[2]);

		// Independent random press and release lengths on every channel
		for (int ch = 0; ch < NUM_SWITCH; ch++)
		begin
			hold_left[ch] = $urandom_range(60, 1);
		end
		repeat (RAND_CYC)
		begin
			@(posedge clk);
			for (int ch = 0; ch < NUM_SWITCH; ch++)
			begin
				if (hold_left[ch] == 0)
				begin
					switch_input[ch] <= ~switch_input[ch];
					hold_left[ch] = $urandom_range(60, 1);
				end
				else
				begin
					hold_left[ch] = hold_left[ch] - 1;
				end
			end
		end
		@(posedge clk);
		switch_input <= '1;
		wait_cycles(SETTLE_CYC - 1);
		@(negedge clk);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== verilog/button_panel.sv ====
// ******************************
// Button panel top
// ******************************

`timescale 1ns/100ps

module button_panel
#(
	parameter int unsigned NUM_SWITCH = 4,
	parameter bit ACTIVE_HIGH = 1'b0,
	parameter int unsigned CLK_PER_TICK = 100,
	parameter int unsigned LOCK_TICKS = 500000
)
(
	input logic clk,
	input logic rstnn,
	input logic [NUM_SWITCH-1:0] switch_input,
	output panel_pkg::switch_count_t [NUM_SWITCH-1:0] value
);

	// ******************************
	// Common time base
	// ******************************

	// Shared lockout tick, one cycle wide
	logic tick;

	tick_gen
	#(
		.CLK_PER_TICK(CLK_PER_TICK)
	)
	tick_gen0
	(
		.clk(clk),
		.rstnn(rstnn),
		.tick(tick)
	);

	// ******************************
	// Switch channels
	// ******************************

	// One independent channel per switch
	// Every channel sees the same tick, so lockouts line up in length
	// but not in phase
	genvar ch;

	generate
		for (ch = 0; ch < NUM_SWITCH; ch = ch + 1)
		begin : g_channel
			switch_to_counter
			#(
				.ACTIVE_HIGH(ACTIVE_HIGH),
				.LOCK_TICKS(LOCK_TICKS)
			)
			channel
			(
				.clk(clk),
				.rstnn(rstnn),
				.tick(tick),
				.switch_input(switch_input[ch]),
				.value(value[ch])
			);
		end
	endgenerate

endmodule

// ==== verilog/switch_to_counter.sv ====
// ******************************
// Switch press channel
// ******************************

`timescale 1ns/100ps

module switch_to_counter
#(
	parameter bit ACTIVE_HIGH = 1'b0,
	parameter int unsigned LOCK_TICKS = 500000
)
(
	input logic clk,
	input logic rstnn,
	input logic tick,
	input logic switch_input,
	output panel_pkg::switch_count_t value
);

	import panel_pkg::*;

	// ******************************
	// Lockout timer sizing
	// ******************************

	// Timer counts ticks from zero to LOCK_TICKS-1 while locked
	localparam int unsigned TIMER_LAST = LOCK_TICKS - 1;

	// Register width for the timer
	localparam int unsigned TIMER_W = bits_for(TIMER_LAST);

	// ******************************
	// Input synchronizer
	// ******************************

	// Switch level with the polarity made active high
	logic raw_pressed;

	// First stage, may go metastable
	logic sync_meta;

	// Second stage, safe to use in the clk domain
	logic sync_stable;

	// Debounce-side view of the switch
	logic pressed;

	// Low-active switches are flipped before sampling
	// A cleared flop then reads as released right after reset
	assign raw_pressed = ACTIVE_HIGH ? switch_input : ~switch_input;

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			sync_meta <= 1'b0;
			sync_stable <= 1'b0;
		end
		else
		begin
			sync_meta <= raw_pressed;
			sync_stable <= sync_meta;
		end
	end

	assign pressed = sync_stable;

	// ******************************
	// Idle and locked FSM
	// ******************************

	lock_state_t state;

	// Lockout timer and press counter
	step_counter_if #(.W(TIMER_W)) timer_bus();
	step_counter_if #(.W(COUNT_W)) press_bus();

	// Lockout is over on the tick where the timer holds its last number
	logic lock_done;

	assign lock_done = tick & timer_bus.last;

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			state <= IDLE;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					// Same edge bumps the press count
					if (pressed)
					begin
						state <= LOCKED;
					end
				end
				LOCKED:
				begin
					// Bounces are ignored until the lockout ends
					if (lock_done)
					begin
						state <= IDLE;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// ******************************
	// Lockout timer
	// ******************************

	// Runs only while locked and steps once per tick
	// Wraps to zero on the last tick, ready for the next lock
	assign timer_bus.enable = (state == LOCKED);
	assign timer_bus.count = tick;

	step_counter
	#(
		.BW(TIMER_W),
		.LAST_NUMBER(TIMER_LAST)
	)
	lock_timer
	(
		.clk(clk),
		.rstnn(rstnn),
		.bus(timer_bus)
	);

	// ******************************
	// Press counter
	// ******************************

	// Counts a press only from IDLE
	// A held switch counts again as soon as the lockout lets go
	assign press_bus.enable = (state == IDLE);
	assign press_bus.count = pressed;

	step_counter
	#(
		.BW(COUNT_W),
		.LAST_NUMBER(COUNT_LAST)
	)
	press_counter
	(
		.clk(clk),
		.rstnn(rstnn),
		.bus(press_bus)
	);

	// Count leaves the channel unchanged
	assign value = press_bus.value;

endmodule

// ==== verilog/tick_gen.sv ====
// ******************************
// Tick divider
// ******************************

`timescale 1ns/100ps

module tick_gen
#(
	parameter int unsigned CLK_PER_TICK = 100
)
(
	input logic clk,
	input logic rstnn,
	output logic tick
);

	import panel_pkg::*;

	// ******************************
	// Divider sizing
	// ******************************

	// Divider runs from zero up to CLK_PER_TICK-1
	localparam int unsigned DIV_W = bits_for(CLK_PER_TICK - 1);

	// Final divider state, the tick cycle
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_PER_TICK - 1);

	// ******************************
	// Free-running divider
	// ******************************

	logic [DIV_W-1:0] div_q;

	// Divider sits on its final state
	logic div_wrap;

	assign div_wrap = (div_q == DIV_LAST);

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			div_q <= '0;
		end
		else if (div_wrap)
		begin
			// Start the next period
			div_q <= '0;
		end
		else
		begin
			div_q <= div_q + 1'b1;
		end
	end

	// ******************************
	// Tick pulse
	// ******************************

	// One cycle high per period, in the CLK_PER_TICK-th cycle after reset
	// and every CLK_PER_TICK cycles after that
	assign tick = div_wrap;

endmodule

// ==== verilog/step_counter.sv ====
// ******************************
// Wrapping step counter
// ******************************

`timescale 1ns/100ps

module step_counter
#(
	parameter int unsigned BW = 8,
	parameter int unsigned LAST_NUMBER = (2 ** BW) - 1
)
(
	input logic clk,
	input logic rstnn,
	step_counter_if.core bus
);

	// ******************************
	// Constants
	// ******************************

	// Last number in the counter's own width
	localparam logic [BW-1:0] LAST_VALUE = BW'(LAST_NUMBER);

	// Zero in the counter's own width
	localparam logic [BW-1:0] FIRST_VALUE = '0;

	// ******************************
	// Value register
	// ******************************

	logic [BW-1:0] value_q;

	// Step condition, both the level and the strobe are needed
	logic do_step;

	// Value reached its final number
	logic at_last;

	assign do_step = bus.enable & bus.count;

	assign at_last = (value_q == LAST_VALUE);

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			value_q <= FIRST_VALUE;
		end
		else if (do_step)
		begin
			// Wrap from the last number back to zero
			if (at_last)
			begin
				value_q <= FIRST_VALUE;
			end
			else
			begin
				value_q <= value_q + 1'b1;
			end
		end
	end

	// ******************************
	// Outputs
	// ******************************

	// Value goes straight out of the register
	assign bus.value = value_q;

	// Last flag follows the register, not the step, so the controller
	// can combine it with its own strobe in the same cycle
	assign bus.last = at_last;

endmodule

// ==== verilog/step_counter_if.sv ====
// ******************************
// Step counter bundle
// ******************************

`timescale 1ns/100ps

interface step_counter_if
#(
	parameter int unsigned W = 8
);

	// Level from the controlling side, the counter holds while low
	logic enable;

	// One-cycle strobe, a step is taken when enable is also high
	logic count;

	// Current counter value
	logic [W-1:0] value;

	// High while value sits on the counter's last number
	logic last;

	// ******************************
	// Views
	// ******************************

	// The block that decides when to step
	modport ctrl
	(
		output enable,
		output count,
		input value,
		input last
	);

	// The counter register itself
	modport core
	(
		input enable,
		input count,
		output value,
		output last
	);

endinterface

// ==== verilog/panel_pkg.sv ====
// ******************************
// Button panel shared types
// ******************************

package panel_pkg;

	// ******************************
	// Press count
	// ******************************

	// Width of one channel's press count
	// One byte per switch is enough for a front panel
	localparam int unsigned COUNT_W = 8;

	// Highest count before the press counter wraps to zero
	localparam int unsigned COUNT_LAST = (2 ** COUNT_W) - 1;

	// One channel's press count as seen at the top level
	typedef logic [COUNT_W-1:0] switch_count_t;

	// ******************************
	// Channel state machine
	// ******************************

	// IDLE accepts a new press
	// LOCKED ignores the switch until the lockout runs out
	typedef enum logic
	{
		IDLE = 1'b0,
		LOCKED = 1'b1
	} lock_state_t;

	// ******************************
	// Width helper
	// ******************************

	// Number of bits needed to hold max_value as an unsigned number
	// Never less than one, so a counter of a single state still has a register
	function automatic int unsigned bits_for(input int unsigned max_value);
		int unsigned width;
		int unsigned rest;
		width = 1;
		rest = max_value >> 1;
		// One more bit for every halving until nothing is left
		while (rest != 0)
		begin
			width = width + 1;
			rest = rest >> 1;
		end
		return width;
	endfunction

endpackage
